// ==== src/uart_pkg.sv ====
package uart_pkg;

   // Character layout.
   localparam int DATA_BITS     = 8;
   localparam int CHARS_PER_CMD = 2; // High byte goes out first.

   // Transmit sequence, one pass per character.
   typedef enum logic [2:0] {
      idle,
      start_bit,
      data_bits,
      parity_bit,
      stop_bit
   } tx_state_e;

   // The receiver walks the same fields on its own.
   typedef enum logic [2:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_parity,
      rx_stop
   } rx_state_e;

   // One received character.
   typedef struct packed {
      logic [DATA_BITS-1:0] data;
      logic                 parity_err; // Set when data plus parity has an even ones count.
   } uart_char_t;

endpackage

// ==== src/uart_bit_timer.sv ====
`timescale 1ns/1ps

module uart_bit_timer #(
   parameter int clks_per_bit = 8
) (
   input  logic clk,
   input  logic rst_n,
   input  logic restart,
   output logic bit_tick,
   output logic mid_tick
);

   localparam int CW = (clks_per_bit > 2) ? $clog2(clks_per_bit) : 1;

   logic [CW-1:0] cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (restart || cnt == CW'(clks_per_bit - 1)) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + CW'(1);
      end
   end

   // Ticks are masked in the restart cycle.
   assign bit_tick = !restart && (cnt == CW'(clks_per_bit - 1));
   assign mid_tick = !restart && (cnt == CW'(clks_per_bit / 2 - 1));

endmodule

// ==== src/uart_tx_fsm.sv ====
`timescale 1ns/1ps

module uart_tx_fsm import uart_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      cmd_vld,
   input  logic      bit_tick,
   output logic      cmd_rdy,
   output logic      load,
   output logic      tx_restart,
   output tx_state_e state,
   output logic [2:0] bit_idx,
   output logic      byte_sel
);

   logic accept;

   assign cmd_rdy = (state == idle);
   assign accept  = cmd_vld && cmd_rdy;

   // Shifter captures and the timer restarts on the accepting edge.
   assign load       = accept;
   assign tx_restart = accept;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= idle;
         bit_idx  <= '0;
         byte_sel <= 1'b0;
      end else begin
         case (state)
            idle: begin
               if (accept) begin
                  state    <= start_bit;
                  bit_idx  <= '0;
                  byte_sel <= 1'b1; // High byte first.
               end
            end
            start_bit: begin
               if (bit_tick) begin
                  state <= data_bits;
               end
            end
            data_bits: begin
               if (bit_tick) begin
                  if (bit_idx == 3'(DATA_BITS - 1)) begin
                     state   <= parity_bit;
                     bit_idx <= '0;
                  end else begin
                     bit_idx <= bit_idx + 3'd1;
                  end
               end
            end
            parity_bit: begin
               if (bit_tick) begin
                  state <= stop_bit;
               end
            end
            stop_bit: begin
               if (bit_tick) begin
                  if (byte_sel) begin
                     // Second character follows without a gap.
                     byte_sel <= 1'b0;
                     state    <= start_bit;
                  end else begin
                     state <= idle;
                  end
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

endmodule

// ==== src/uart_tx_shifter.sv ====
`timescale 1ns/1ps

module uart_tx_shifter import uart_pkg::*; (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [CHARS_PER_CMD*DATA_BITS-1:0]  cmd_in,
   input  logic                                load,
   input  tx_state_e                           state,
   input  logic [2:0]                          bit_idx,
   input  logic                                byte_sel,
   output logic                                tx
);

   logic [CHARS_PER_CMD*DATA_BITS-1:0] cmd_q;
   logic [CHARS_PER_CMD-1:0]           par_q;
   logic [DATA_BITS-1:0]               cur_byte;

   // Command and its odd parity bits stay for the whole frame.
   always_ff @(posedge clk) begin
      if (load) begin
         cmd_q <= cmd_in;
         for (int i = 0; i < CHARS_PER_CMD; i++) begin
            par_q[i] <= ~^cmd_in[i*DATA_BITS +: DATA_BITS];
         end
      end
   end

   assign cur_byte = cmd_q[DATA_BITS*int'(byte_sel) +: DATA_BITS];

   // Line lags the state machine by one cycle.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx <= 1'b1;
      end else begin
         case (state)
            start_bit:  tx <= 1'b0;
            data_bits:  tx <= cur_byte[bit_idx]; // LSB first.
            parity_bit: tx <= par_q[byte_sel];
            default:    tx <= 1'b1; // Stop and idle.
         endcase
      end
   end

endmodule

// ==== src/uart_rx_sampler.sv ====
`timescale 1ns/1ps

module uart_rx_sampler import uart_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       rx,
   input  logic       mid_tick,
   output logic       rx_restart,
   output uart_char_t rx_char,
   output logic       read_rdy
);

   rx_state_e            rx_state;
   logic                 rx_s1;
   logic                 rx_s2;
   logic                 rx_prev;
   logic [2:0]           bit_cnt;
   logic [DATA_BITS-1:0] rx_shift;
   logic                 rx_par;

   // Two-flop synchronizer plus one more stage for edge detection.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_s1   <= 1'b1;
         rx_s2   <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_s1   <= rx;
         rx_s2   <= rx_s1;
         rx_prev <= rx_s2;
      end
   end

   assign rx_restart = (rx_state == rx_idle) && rx_prev && !rx_s2;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_state <= rx_idle;
         bit_cnt  <= '0;
         read_rdy <= 1'b0;
      end else begin
         read_rdy <= 1'b0;
         case (rx_state)
            rx_idle: begin
               if (rx_restart) begin
                  rx_state <= rx_start;
               end
            end
            rx_start: begin
               if (mid_tick) begin
                  // Glitch if the line is already high again.
                  rx_state <= rx_s2 ? rx_idle : rx_data;
                  bit_cnt  <= '0;
               end
            end
            rx_data: begin
               if (mid_tick) begin
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'(DATA_BITS - 1)) begin
                     rx_state <= rx_parity;
                  end
               end
            end
            rx_parity: begin
               if (mid_tick) begin
                  rx_state <= rx_stop;
               end
            end
            rx_stop: begin
               if (mid_tick) begin
                  read_rdy <= 1'b1; // Delivered even with a low stop bit.
                  rx_state <= rx_idle;
               end
            end
            default: begin
               rx_state <= rx_idle;
            end
         endcase
      end
   end

   // Payload path.
   always_ff @(posedge clk) begin
      if (mid_tick) begin
         if (rx_state == rx_data) begin
            rx_shift <= {rx_s2, rx_shift[DATA_BITS-1:1]};
         end
         if (rx_state == rx_parity) begin
            rx_par <= rx_s2;
         end
         if (rx_state == rx_stop) begin
            rx_char.data       <= rx_shift;
            rx_char.parity_err <= ~^{rx_shift, rx_par};
         end
      end
   end

endmodule

// ==== src/uart_top.sv ====
`timescale 1ns/1ps

module uart_top import uart_pkg::*; #(
   parameter int clks_per_bit = 8
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic [CHARS_PER_CMD*DATA_BITS-1:0] cmd_in,
   input  logic                               cmd_vld,
   output logic                               cmd_rdy,
   input  logic                               rx,
   output logic                               tx,
   output uart_char_t                         rx_char,
   output logic                               read_rdy
);

   tx_state_e  state;
   logic [2:0] bit_idx;
   logic       byte_sel;
   logic       load;
   logic       tx_restart;
   logic       tx_bit_tick;
   logic       rx_restart;
   logic       rx_mid_tick;

   uart_tx_fsm i_tx_fsm (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_vld    (cmd_vld),
      .bit_tick   (tx_bit_tick),
      .cmd_rdy    (cmd_rdy),
      .load       (load),
      .tx_restart (tx_restart),
      .state      (state),
      .bit_idx    (bit_idx),
      .byte_sel   (byte_sel)
   );

   uart_bit_timer #(.clks_per_bit(clks_per_bit)) i_tx_timer (
      .clk      (clk),
      .rst_n    (rst_n),
      .restart  (tx_restart),
      .bit_tick (tx_bit_tick),
      .mid_tick ()
   );

   uart_tx_shifter i_tx_shifter (
      .clk      (clk),
      .rst_n    (rst_n),
      .cmd_in   (cmd_in),
      .load     (load),
      .state    (state),
      .bit_idx  (bit_idx),
      .byte_sel (byte_sel),
      .tx       (tx)
   );

   // Receive side runs on its own timer.
   uart_bit_timer #(.clks_per_bit(clks_per_bit)) i_rx_timer (
      .clk      (clk),
      .rst_n    (rst_n),
      .restart  (rx_restart),
      .bit_tick (),
      .mid_tick (rx_mid_tick)
   );

   uart_rx_sampler i_rx_sampler (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx         (rx),
      .mid_tick   (rx_mid_tick),
      .rx_restart (rx_restart),
      .rx_char    (rx_char),
      .read_rdy   (read_rdy)
   );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
   parameter int period_ns    = 8,
   parameter int reset_cycles = 3
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

   // Release lands on a falling edge.
   initial begin
      rst_n = 1'b0;
      #(reset_cycles * period_ns);
      rst_n = 1'b1;
   end

endmodule

// ==== test/uart_sva.sv ====
`timescale 1ns/1ps

module uart_sva import uart_pkg::*; #(
   parameter int clks_per_bit = 8
) (
   input logic      clk,
   input logic      rst_n,
   input tx_state_e state,
   input logic      tx,
   input logic      cmd_vld,
   input logic      cmd_rdy,
   input logic      read_rdy
);

   localparam int FRAME_CYCLES = CHARS_PER_CMD * (DATA_BITS + 3) * clks_per_bit;

   int busy_left; // Cycles left in the running frame.

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_left <= 0;
      end else if (cmd_vld && cmd_rdy) begin
         busy_left <= FRAME_CYCLES;
      end else if (busy_left != 0) begin
         busy_left <= busy_left - 1;
      end
   end

   // Line rests high outside a frame.
   idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
      (state == idle) |-> tx)
      else $error("tx is low while the transmit FSM is idle");

   single_read_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      read_rdy |=> !read_rdy)
      else $error("read_rdy stayed high for two cycles");

   accept_starts_frame: assert property (@(posedge clk) disable iff (!rst_n)
      (cmd_vld && cmd_rdy) |=> (state == start_bit))
      else $error("accepted command did not start a frame");

   busy_until_frame_end: assert property (@(posedge clk) disable iff (!rst_n)
      (busy_left != 0) |-> !cmd_rdy)
      else $error("cmd_rdy rose before the frame ended");

   ready_after_frame: assert property (@(posedge clk) disable iff (!rst_n)
      (busy_left == 1) |=> cmd_rdy)
      else $error("cmd_rdy did not rise when the frame ended");

endmodule

bind uart_top uart_sva #(.clks_per_bit(clks_per_bit)) i_uart_sva (
   .clk      (clk),
   .rst_n    (rst_n),
   .state    (state),
   .tx       (tx),
   .cmd_vld  (cmd_vld),
   .cmd_rdy  (cmd_rdy),
   .read_rdy (read_rdy)
);

// ==== test/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb import uart_pkg::*; ();

   localparam int CLKS_PER_BIT = 8;
   localparam int CLK_NS       = 8;
   localparam int FRAME_BITS   = 22;
   localparam int N_RANDOM     = 20;
   localparam int N_CMDS       = N_RANDOM + 2; // Plus the fixed and the busy command.
   localparam int N_CHARS      = 2 * N_CMDS + 2;
   localparam int WATCHDOG_NS  = (N_CMDS + 1) * FRAME_BITS * CLKS_PER_BIT * CLK_NS * 2 + 2000;

   logic                  clk;
   logic                  rst_n;
   logic [15:0]           cmd_in;
   logic                  cmd_vld;
   logic                  cmd_rdy;
   logic                  tx;
   logic                  rx;
   logic                  drv_rx;
   logic                  loop_en;
   logic                  read_rdy;
   uart_char_t            rx_char;
   logic [FRAME_BITS-1:0] exp_frames[$];
   uart_char_t            exp_chars[$];
   int                    frames_checked;
   int                    chars_checked;
   logic [31:0]           rng;

   tb_clock #(.period_ns(CLK_NS), .reset_cycles(3)) i_tb_clock (.clk(clk), .rst_n(rst_n));

   uart_top #(.clks_per_bit(CLKS_PER_BIT)) i_uart_top (
      .clk      (clk),
      .rst_n    (rst_n),
      .cmd_in   (cmd_in),
      .cmd_vld  (cmd_vld),
      .cmd_rdy  (cmd_rdy),
      .rx       (rx),
      .tx       (tx),
      .rx_char  (rx_char),
      .read_rdy (read_rdy)
   );

   assign rx = loop_en ? tx : drv_rx;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped on the first error");
   endtask

   // One for a byte with an even ones count.
   function automatic logic odd_parity(input logic [7:0] b);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++) begin
         if (b[i]) begin
            ones++;
         end
      end
      return (ones % 2 == 0);
   endfunction

   // Bit i is the i-th bit on the line.
   function automatic logic [FRAME_BITS-1:0] ref_frame(input logic [15:0] cmd);
      logic [FRAME_BITS-1:0] f;
      logic [7:0]            b;
      for (int c = 0; c < 2; c++) begin
         b = (c == 0) ? cmd[15:8] : cmd[7:0];
         f[c*11] = 1'b0;
         for (int i = 0; i < 8; i++) begin
            f[c*11 + 1 + i] = b[i];
         end
         f[c*11 + 9]  = odd_parity(b);
         f[c*11 + 10] = 1'b1;
      end
      return f;
   endfunction

   function automatic uart_char_t ref_char(input logic [7:0] b, input logic par);
      uart_char_t c;
      c.data       = b;
      c.parity_err = (par != odd_parity(b));
      return c;
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Called on a falling edge; returns one falling edge after acceptance.
   task automatic send_cmd(input logic [15:0] cmd);
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      while (!cmd_rdy) begin
         @(negedge clk);
      end
      exp_frames.push_back(ref_frame(cmd));
      exp_chars.push_back(ref_char(cmd[15:8], odd_parity(cmd[15:8])));
      exp_chars.push_back(ref_char(cmd[7:0], odd_parity(cmd[7:0])));
      @(negedge clk);
      cmd_vld = 1'b0;
   endtask

   task automatic drive_char(input logic [7:0] b, input logic par);
      logic [10:0] bits;
      bits = {1'b1, par, b, 1'b0};
      for (int i = 0; i < 11; i++) begin
         drv_rx = bits[i];
         repeat (CLKS_PER_BIT) @(negedge clk);
      end
   endtask

   task automatic wait_idle();
      while (exp_frames.size() != 0 || exp_chars.size() != 0 || !cmd_rdy) begin
         @(negedge clk);
      end
   endtask

   initial begin : line_monitor
      logic [FRAME_BITS-1:0] got;
      logic [FRAME_BITS-1:0] want;
      wait (rst_n);
      forever begin
         @(negedge tx);
         repeat (CLKS_PER_BIT / 2) @(negedge clk); // Mid-bit.
         for (int i = 0; i < FRAME_BITS; i++) begin
            if (i != 0) begin
               repeat (CLKS_PER_BIT) @(negedge clk);
            end
            got[i] = tx;
         end
         assert (exp_frames.size() != 0)
            else fail_run("tx sent a frame while no command was pending");
         want = exp_frames.pop_front();
         assert (got == want)
            else fail_run($sformatf("mismatch tx frame: got %h, expected %h", got, want));
         frames_checked++;
      end
   end

   initial begin : char_checker
      uart_char_t want;
      wait (rst_n);
      forever begin
         @(negedge clk);
         if (read_rdy) begin
            assert (exp_chars.size() != 0)
               else fail_run("read_rdy pulsed while no character was expected");
            want = exp_chars.pop_front();
            assert (rx_char.data == want.data)
               else fail_run($sformatf("mismatch rx_char.data: got %h, expected %h",
                                       rx_char.data, want.data));
            assert (rx_char.parity_err == want.parity_err)
               else fail_run($sformatf("mismatch rx_char.parity_err: got %h, expected %h",
                                       rx_char.parity_err, want.parity_err));
            chars_checked++;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      fail_run("watchdog expired before the tests finished");
   end

   initial begin : stimulus
      cmd_in         = '0;
      cmd_vld        = 1'b0;
      drv_rx         = 1'b1;
      loop_en        = 1'b1;
      frames_checked = 0;
      chars_checked  = 0;
      rng            = 32'h9b8f;
      wait (rst_n);
      @(negedge clk);

      assert (tx == 1'b1) else fail_run($sformatf("mismatch tx: got %h, expected 1", tx));
      assert (cmd_rdy == 1'b1)
         else fail_run($sformatf("mismatch cmd_rdy: got %h, expected 1", cmd_rdy));
      assert (read_rdy == 1'b0)
         else fail_run($sformatf("mismatch read_rdy: got %h, expected 0", read_rdy));

      // Fixed command, line format and loopback.
      send_cmd(16'hA53C);
      wait_idle();

      // Other data offered while busy.
      send_cmd(16'h1E7F);
      cmd_in  = 16'hC0DE;
      cmd_vld = 1'b1;
      repeat (3 * CLKS_PER_BIT) begin
         @(negedge clk);
         assert (cmd_rdy == 1'b0)
            else fail_run($sformatf("mismatch cmd_rdy: got %h, expected 0", cmd_rdy));
      end
      cmd_vld = 1'b0;
      wait_idle();

      // Bad parity, then a clean character.
      loop_en = 1'b0;
      @(negedge clk);
      exp_chars.push_back(ref_char(8'h5A, !odd_parity(8'h5A)));
      drive_char(8'h5A, !odd_parity(8'h5A));
      exp_chars.push_back(ref_char(8'hC3, odd_parity(8'hC3)));
      drive_char(8'hC3, odd_parity(8'hC3));
      wait_idle();
      loop_en = 1'b1;

      for (int n = 0; n < N_RANDOM; n++) begin
         rng = xorshift(rng);
         send_cmd(rng[15:0]);
      end
      wait_idle();
      repeat (2 * CLKS_PER_BIT) @(negedge clk);

      if (exp_frames.size() == 0 && exp_chars.size() == 0 &&
          frames_checked == N_CMDS && chars_checked == N_CHARS) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         fail_run($sformatf("only %0d frames and %0d characters were checked",
                            frames_checked, chars_checked));
      end
   end

endmodule

// ==== tb.f ====
src/uart_pkg.sv
src/uart_bit_timer.sv
src/uart_tx_fsm.sv
src/uart_tx_shifter.sv
src/uart_rx_sampler.sv
src/uart_top.sv
test/tb_clock.sv
test/uart_sva.sv
test/uart_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module uart_tb -f tb.f -o uart_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/uart_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
   exit "$status"
fi

exit 0
